// File: common/mem_types_pkg.sv
package mem_types_pkg;

    // linear address and operand widths.
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;

    // 0 = 1 byte, 1 = 2 bytes, 2 = 4 bytes, 3 = 8 bytes.
    typedef logic [1:0] size_t;

    // one-hot override, lowest set bit selects the size.
    typedef logic [3:0] size_ovr_t;

    typedef logic [15:0] seg_t;
    typedef logic [19:0] seg_lim_t;

    typedef logic [3:0] ie_type_t;
    typedef logic [4:0] aluk_t;

    // operand sources, codes 6 and 7 select zero.
    typedef enum logic [2:0] {
        SRC_REG1 = 3'd0,
        SRC_REG2 = 3'd1,
        SRC_SEG  = 3'd2,
        SRC_MEM  = 3'd3,
        SRC_IMM  = 3'd4,
        SRC_EIP  = 3'd5
    } op_src_t;

endpackage

// File: common/mem_cfg_pkg.sv
package mem_cfg_pkg;

    // data RAM geometry, 64-bit words.
    localparam int RAM_WORDS = 256;
    localparam int RAM_IDX_W = 8;
    localparam int RAM_OFF_W = 3;

    // operand size codes.
    localparam logic [1:0] SZ_BYTE  = 2'd0;
    localparam logic [1:0] SZ_WORD  = 2'd1;
    localparam logic [1:0] SZ_DWORD = 2'd2;
    localparam logic [1:0] SZ_QWORD = 2'd3;

    // exception type bit positions.
    localparam int IE_PROT_BIT = 0;

endpackage

// File: hw/addr_gen.sv
`timescale 1ns/1ps

module addr_gen
    import mem_types_pkg::*;
(
    input  size_t     opsize_in,
    input  size_ovr_t size_ovr_in,
    input  logic      is_push,
    input  addr_t     mem_addr2,
    output size_t     size_eff,
    output addr_t     mem2_eff
);

    addr_t push_dec;

    // lowest set override bit wins.
    always_comb begin
        if (size_ovr_in[0]) begin
            size_eff = 2'd0;
        end else if (size_ovr_in[1]) begin
            size_eff = 2'd1;
        end else if (size_ovr_in[2]) begin
            size_eff = 2'd2;
        end else if (size_ovr_in[3]) begin
            size_eff = 2'd3;
        end else begin
            size_eff = opsize_in;
        end
    end

    // bytes pushed, 1 << size.
    assign push_dec = addr_t'(32'd1 << size_eff);

    // stack pointer is pre-decremented for a push.
    assign mem2_eff = is_push ? (mem_addr2 - push_dec) : mem_addr2;

endmodule

// File: hw/seg_limit_check.sv
`timescale 1ns/1ps

module seg_limit_check
    import mem_types_pkg::*;
(
    input  addr_t    end_addr,
    input  seg_lim_t seg_lim,
    input  logic     access,
    input  logic     end_valid,
    output logic     violation
);

    addr_t lim_ext;
    logic  over;

    assign lim_ext = {12'd0, seg_lim};
    assign over    = end_addr > lim_ext;

    // only a real access with a known end address can fault.
    assign violation = access & end_valid & over;

endmodule

// File: hw/operand_select.sv
`timescale 1ns/1ps

module operand_select
    import mem_types_pkg::*;
(
    input  op_src_t op1_src,
    input  op_src_t op2_src,
    input  data_t   reg1,
    input  data_t   reg2,
    input  seg_t    seg_val,
    input  data_t   load_data,
    input  data_t   imm,
    input  addr_t   eip,
    output data_t   op1_val,
    output data_t   op2_val
);

    function automatic data_t pick(
        input op_src_t src,
        input data_t   r1,
        input data_t   r2,
        input seg_t    sg,
        input data_t   ld,
        input data_t   im,
        input addr_t   ip
    );
        case (src)
            SRC_REG1: pick = r1;
            SRC_REG2: pick = r2;
            SRC_SEG:  pick = {48'd0, sg};
            SRC_MEM:  pick = ld;
            SRC_IMM:  pick = im;
            SRC_EIP:  pick = {32'd0, ip};
            default:  pick = '0;
        endcase
    endfunction

    always_comb begin
        op1_val = pick(op1_src, reg1, reg2, seg_val, load_data, imm, eip);
        op2_val = pick(op2_src, reg1, reg2, seg_val, load_data, imm, eip);
    end

endmodule

// File: data_ram/data_ram.sv
`timescale 1ns/1ps

module data_ram
    import mem_types_pkg::*;
    import mem_cfg_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  rd_en,
    input  addr_t rd_addr,
    input  size_t rd_size,
    input  logic  wr_en,
    input  addr_t wr_addr,
    input  data_t wr_data,
    input  size_t wr_size,
    output data_t rd_data
);

    data_t mem [RAM_WORDS];

    logic [RAM_IDX_W-1:0] rd_idx;
    logic [RAM_IDX_W-1:0] wr_idx;
    logic [RAM_OFF_W-1:0] rd_off;
    logic [RAM_OFF_W-1:0] wr_off;
    logic [7:0]           wr_be;
    logic [7:0]           rd_lanes;
    data_t                wr_word;
    data_t                rd_mask;
    data_t                rd_word;

    // byte lanes covered by an access of the given size.
    function automatic logic [7:0] size_lanes(input size_t sz);
        case (sz)
            SZ_BYTE:  size_lanes = 8'h01;
            SZ_WORD:  size_lanes = 8'h03;
            SZ_DWORD: size_lanes = 8'h0f;
            SZ_QWORD: size_lanes = 8'hff;
            default:  size_lanes = 8'h00;
        endcase
    endfunction

    assign rd_idx = rd_addr[RAM_OFF_W +: RAM_IDX_W];
    assign wr_idx = wr_addr[RAM_OFF_W +: RAM_IDX_W];
    assign rd_off = rd_addr[RAM_OFF_W-1:0];
    assign wr_off = wr_addr[RAM_OFF_W-1:0];

    // lanes past the top of the word fall off the shift.
    assign wr_be   = size_lanes(wr_size) << wr_off;
    assign wr_word = wr_data << {wr_off, 3'b000};

    assign rd_lanes = size_lanes(rd_size);

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            rd_mask[8*i +: 8] = {8{rd_lanes[i]}};
        end
    end

    assign rd_word = (mem[rd_idx] >> {rd_off, 3'b000}) & rd_mask;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < 8; i++) begin
                if (wr_be[i]) begin
                    mem[wr_idx][8*i +: 8] <= wr_word[8*i +: 8];
                end
            end
        end
    end

    // same-cycle write to the read word returns the old bytes.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= rd_word;
        end
    end

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
    import mem_types_pkg::*;
    import mem_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      valid_in,
    input  size_t     opsize_in,
    input  size_ovr_t size_ovr_in,
    input  logic      is_push,
    input  addr_t     mem_addr1,
    input  addr_t     mem_addr2,
    input  logic      mem1_access,
    input  logic      mem2_access,
    input  addr_t     mem1_end,
    input  addr_t     mem2_end,
    input  addr_t     eip_end,
    input  logic      mem1_end_valid,
    input  logic      mem2_end_valid,
    input  logic      eip_end_valid,
    input  seg_lim_t  seg1_lim,
    input  seg_lim_t  seg2_lim,
    input  seg_lim_t  cs_lim,
    input  data_t     reg1,
    input  data_t     reg2,
    input  seg_t      seg_val,
    input  data_t     imm,
    input  addr_t     eip_in,
    input  op_src_t   op1_src,
    input  op_src_t   op2_src,
    input  logic      ie_in,
    input  ie_type_t  ie_type_in,
    input  aluk_t     aluk_in,
    input  logic      fwd_stall,
    input  logic      wb_valid,
    input  addr_t     wb_addr,
    input  data_t     wb_data,
    input  size_t     wb_size,
    output logic      stall,
    output logic      valid_out,
    output data_t     op1_val,
    output data_t     op2_val,
    output addr_t     dest_addr,
    output size_t     size_out,
    output logic      ie_out,
    output ie_type_t  ie_type_out,
    output aluk_t     aluk_out
);

    size_t    size_eff;
    addr_t    mem2_eff;
    data_t    load_data;
    logic     prot1;
    logic     prot2;
    logic     prot3;
    logic     prot;
    logic     load;
    logic     accept;
    ie_type_t ie_type_mrg;

    op_src_t  op1_src_q;
    op_src_t  op2_src_q;
    data_t    reg1_q;
    data_t    reg2_q;
    seg_t     seg_q;
    data_t    imm_q;
    addr_t    eip_q;

    // next stage only blocks us when we hold a valid result.
    assign stall  = fwd_stall & valid_out;
    assign load   = ~stall;
    assign accept = load & valid_in;

    addr_gen u_addr_gen (
        .opsize_in   (opsize_in),
        .size_ovr_in (size_ovr_in),
        .is_push     (is_push),
        .mem_addr2   (mem_addr2),
        .size_eff    (size_eff),
        .mem2_eff    (mem2_eff)
    );

    seg_limit_check u_lim1 (
        .end_addr  (mem1_end),
        .seg_lim   (seg1_lim),
        .access    (mem1_access),
        .end_valid (mem1_end_valid),
        .violation (prot1)
    );

    seg_limit_check u_lim2 (
        .end_addr  (mem2_end),
        .seg_lim   (seg2_lim),
        .access    (mem2_access),
        .end_valid (mem2_end_valid),
        .violation (prot2)
    );

    seg_limit_check u_lim_cs (
        .end_addr  (eip_end),
        .seg_lim   (cs_lim),
        .access    (1'b1),
        .end_valid (eip_end_valid),
        .violation (prot3)
    );

    assign prot = prot1 | prot2 | prot3;

    always_comb begin
        ie_type_mrg = ie_type_in;
        ie_type_mrg[IE_PROT_BIT] = ie_type_in[IE_PROT_BIT] | prot;
    end

    // read data lands together with the registered fields below.
    data_ram u_data_ram (
        .clk     (clk),
        .rst     (rst),
        .rd_en   (accept & mem1_access),
        .rd_addr (mem_addr1),
        .rd_size (size_eff),
        .wr_en   (wb_valid),
        .wr_addr (wb_addr),
        .wr_data (wb_data),
        .wr_size (wb_size),
        .rd_data (load_data)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out   <= 1'b0;
            ie_out      <= 1'b0;
            ie_type_out <= '0;
        end else if (load) begin
            valid_out   <= valid_in;
            ie_out      <= valid_in & (ie_in | prot);
            ie_type_out <= valid_in ? ie_type_mrg : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dest_addr <= mem2_eff;
            size_out  <= size_eff;
            aluk_out  <= aluk_in;
            op1_src_q <= op1_src;
            op2_src_q <= op2_src;
            reg1_q    <= reg1;
            reg2_q    <= reg2;
            seg_q     <= seg_val;
            imm_q     <= imm;
            eip_q     <= eip_in;
        end
    end

    operand_select u_operand_select (
        .op1_src   (op1_src_q),
        .op2_src   (op2_src_q),
        .reg1      (reg1_q),
        .reg2      (reg2_q),
        .seg_val   (seg_q),
        .load_data (load_data),
        .imm       (imm_q),
        .eip       (eip_q),
        .op1_val   (op1_val),
        .op2_val   (op2_val)
    );

endmodule

// File: verification/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset is seen on two rising edges.
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: verification/mem_stage_chk.sv
`timescale 1ns/1ps

module mem_stage_chk
    import mem_types_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     valid_in,
    input logic     stall,
    input logic     valid_out,
    input logic     ie_out,
    input data_t    op1_val,
    input data_t    op2_val,
    input addr_t    dest_addr,
    input size_t    size_out,
    input ie_type_t ie_type_out,
    input aluk_t    aluk_out
);

    // the output register is empty after a reset cycle.
    reset_clears_valid: assert property (@(posedge clk) rst |=> !valid_out)
        else $error("valid_out high right after reset");

    held_under_stall: assert property (@(posedge clk) disable iff (rst)
        stall |=> valid_out && $stable(op1_val) && $stable(op2_val)
            && $stable(dest_addr) && $stable(size_out) && $stable(ie_out)
            && $stable(ie_type_out) && $stable(aluk_out))
        else $error("outputs changed while the stage was stalled");

    // an empty stage takes the next instruction whatever fwd_stall says.
    accept_when_empty: assert property (@(posedge clk) disable iff (rst)
        !valid_out && valid_in |=> valid_out)
        else $error("valid instruction not accepted while valid_out was low");

    ie_needs_valid: assert property (@(posedge clk) disable iff (rst)
        ie_out |-> valid_out)
        else $error("ie_out high without valid_out");

endmodule

bind mem_stage mem_stage_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .valid_in    (valid_in),
    .stall       (stall),
    .valid_out   (valid_out),
    .ie_out      (ie_out),
    .op1_val     (op1_val),
    .op2_val     (op2_val),
    .dest_addr   (dest_addr),
    .size_out    (size_out),
    .ie_type_out (ie_type_out),
    .aluk_out    (aluk_out)
);

// File: verification/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb
    import mem_types_pkg::*;
    import mem_cfg_pkg::*;
();

    localparam int N_INSTR     = 600;
    localparam int MAX_CYCLES  = 20000;
    localparam int DRAIN_LIMIT = 100;
    localparam int RST_LIMIT   = 20;

    // one instruction as presented by the upstream stage.
    typedef struct packed {
        logic      valid;
        size_t     opsize;
        size_ovr_t ovr;
        logic      push;
        addr_t     addr1;
        addr_t     addr2;
        logic      acc1;
        logic      acc2;
        addr_t     end1;
        addr_t     end2;
        addr_t     eend;
        logic      ev1;
        logic      ev2;
        logic      ev3;
        seg_lim_t  lim1;
        seg_lim_t  lim2;
        seg_lim_t  lim_cs;
        data_t     reg1;
        data_t     reg2;
        seg_t      seg;
        data_t     imm;
        addr_t     eip;
        op_src_t   src1;
        op_src_t   src2;
        logic      ie;
        ie_type_t  ie_type;
        aluk_t     aluk;
    } instr_t;

    typedef struct packed {
        data_t    op1;
        data_t    op2;
        addr_t    dest;
        size_t    size;
        logic     ie;
        ie_type_t ie_type;
        aluk_t    aluk;
    } result_t;

    logic     clk;
    logic     rst;
    instr_t   ins;
    logic     fwd_stall;
    logic     wb_valid;
    addr_t    wb_addr;
    data_t    wb_data;
    size_t    wb_size;

    logic     stall;
    logic     valid_out;
    data_t    op1_val;
    data_t    op2_val;
    addr_t    dest_addr;
    size_t    size_out;
    logic     ie_out;
    ie_type_t ie_type_out;
    aluk_t    aluk_out;

    logic [31:0] seed = 32'd76;
    logic [7:0]  ram_model [2048];
    data_t       last_load = '0;
    result_t     exp_q [$];
    int          accepted = 0;
    logic        passed = 1'b0;
    logic        fail_shown = 1'b0;

    clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    mem_stage uut (
        .clk            (clk),
        .rst            (rst),
        .valid_in       (ins.valid),
        .opsize_in      (ins.opsize),
        .size_ovr_in    (ins.ovr),
        .is_push        (ins.push),
        .mem_addr1      (ins.addr1),
        .mem_addr2      (ins.addr2),
        .mem1_access    (ins.acc1),
        .mem2_access    (ins.acc2),
        .mem1_end       (ins.end1),
        .mem2_end       (ins.end2),
        .eip_end        (ins.eend),
        .mem1_end_valid (ins.ev1),
        .mem2_end_valid (ins.ev2),
        .eip_end_valid  (ins.ev3),
        .seg1_lim       (ins.lim1),
        .seg2_lim       (ins.lim2),
        .cs_lim         (ins.lim_cs),
        .reg1           (ins.reg1),
        .reg2           (ins.reg2),
        .seg_val        (ins.seg),
        .imm            (ins.imm),
        .eip_in         (ins.eip),
        .op1_src        (ins.src1),
        .op2_src        (ins.src2),
        .ie_in          (ins.ie),
        .ie_type_in     (ins.ie_type),
        .aluk_in        (ins.aluk),
        .fwd_stall      (fwd_stall),
        .wb_valid       (wb_valid),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .wb_size        (wb_size),
        .stall          (stall),
        .valid_out      (valid_out),
        .op1_val        (op1_val),
        .op2_val        (op2_val),
        .dest_addr      (dest_addr),
        .size_out       (size_out),
        .ie_out         (ie_out),
        .ie_type_out    (ie_type_out),
        .aluk_out       (aluk_out)
    );

    function automatic logic [31:0] rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 15);
    endfunction

    function automatic void show_fail();
        if (!fail_shown) begin
            fail_shown = 1'b1;
            $display("Errors found");
        end
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        show_fail();
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("ERROR %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            report_error($sformatf("ERROR %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            report_error($sformatf("ERROR %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_size(input string name, input size_t got, input size_t exp);
        if (got !== exp) begin
            report_error($sformatf("ERROR %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_ie(input logic got_ie, input ie_type_t got_type,
                            input logic exp_ie, input ie_type_t exp_type);
        if (got_ie !== exp_ie) begin
            report_error($sformatf("ERROR ie_out: got 0x%h expected 0x%h", got_ie, exp_ie));
        end
        if (got_type !== exp_type) begin
            report_error($sformatf("ERROR ie_type_out: got 0x%h expected 0x%h",
                                   got_type, exp_type));
        end
    endtask

    task automatic check_aluk(input string name, input aluk_t got, input aluk_t exp);
        if (got !== exp) begin
            report_error($sformatf("ERROR %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // the highest set bit is overwritten by any lower one.
    function automatic size_t eff_size(input size_t opsize, input size_ovr_t ovr);
        size_t s;
        s = opsize;
        for (int i = 3; i >= 0; i--) begin
            if (ovr[i]) begin
                s = size_t'(i);
            end
        end
        return s;
    endfunction

    // bytes past the end of the 64-bit word read as zero.
    function automatic data_t model_read(input addr_t a, input size_t sz);
        data_t v;
        v = '0;
        for (int b = 0; b < 8; b++) begin
            if (b < (1 << sz) && int'(a[2:0]) + b < 8) begin
                v[8*b +: 8] = ram_model[a[10:0] + 11'(b)];
            end
        end
        return v;
    endfunction

    function automatic void model_write(input addr_t a, input data_t d, input size_t sz);
        for (int b = 0; b < 8; b++) begin
            if (b < (1 << sz) && int'(a[2:0]) + b < 8) begin
                ram_model[a[10:0] + 11'(b)] = d[8*b +: 8];
            end
        end
    endfunction

    function automatic data_t pick_operand(input op_src_t src, input instr_t op,
                                           input data_t ld);
        case (src)
            SRC_REG1: return op.reg1;
            SRC_REG2: return op.reg2;
            SRC_SEG:  return data_t'(op.seg);
            SRC_MEM:  return ld;
            SRC_IMM:  return op.imm;
            SRC_EIP:  return data_t'(op.eip);
            default:  return '0;
        endcase
    endfunction

    function automatic result_t ref_mem_stage(input instr_t op, input data_t ld);
        result_t e;
        size_t   sz;
        logic    prot;
        sz   = eff_size(op.opsize, op.ovr);
        prot = (op.acc1 && op.ev1 && op.end1 > addr_t'(op.lim1))
            || (op.acc2 && op.ev2 && op.end2 > addr_t'(op.lim2))
            || (op.ev3 && op.eend > addr_t'(op.lim_cs));
        e.size    = sz;
        e.dest    = op.push ? op.addr2 - (32'd1 << sz) : op.addr2;
        e.ie      = op.ie | prot;
        e.ie_type = op.ie_type;
        e.ie_type[IE_PROT_BIT] = op.ie_type[IE_PROT_BIT] | prot;
        e.aluk    = op.aluk;
        e.op1     = pick_operand(op.src1, op, ld);
        e.op2     = pick_operand(op.src2, op, ld);
        return e;
    endfunction

    function automatic instr_t random_instr();
        instr_t      n;
        logic [31:0] r;
        logic [31:0] o;
        r = rand32();
        o = rand32();
        n.valid   = r[1:0] != 2'b00;
        n.opsize  = r[3:2];
        n.ovr     = o[4] ? o[3:0] : 4'h0;
        n.push    = r[4];
        n.acc1    = r[5] | r[28];
        n.acc2    = r[6];
        n.ev1     = r[7];
        n.ev2     = r[8];
        n.ev3     = r[9];
        n.ie      = r[12:10] == 3'd0;
        n.ie_type = r[16:13];
        n.aluk    = r[21:17];
        // op1 leans towards loads so the RAM sees plenty of reads.
        n.src1    = r[28] ? SRC_MEM : op_src_t'(r[24:22]);
        n.src2    = op_src_t'(r[27:25]);
        n.addr1   = rand32();
        n.addr2   = rand32();
        n.end1    = rand32() & 32'h001f_ffff;
        n.end2    = rand32() & 32'h001f_ffff;
        n.eend    = rand32() & 32'h001f_ffff;
        n.lim1    = seg_lim_t'(rand32());
        n.lim2    = seg_lim_t'(rand32());
        n.lim_cs  = seg_lim_t'(rand32());
        n.reg1    = {rand32(), rand32()};
        n.reg2    = {rand32(), rand32()};
        n.seg     = seg_t'(rand32());
        n.imm     = {rand32(), rand32()};
        n.eip     = rand32();
        return n;
    endfunction

    // a quarter of the writes hit the word of the pending load.
    task automatic drive_wb(input addr_t load_addr);
        logic [31:0] r;
        size_t       sz;
        addr_t       a;
        r  = rand32();
        sz = r[3:2];
        a  = (r[5:4] == 2'b00) ? load_addr : rand32();
        a  = a & ~((32'd1 << sz) - 32'd1);
        wb_valid <= r[0];
        wb_addr  <= a;
        wb_data  <= {rand32(), rand32()};
        wb_size  <= sz;
    endtask

    initial begin : stimulus
        instr_t      nxt;
        size_t       sz;
        logic [31:0] r;
        int          cycles;
        logic        held;
        ins       = '0;
        fwd_stall = 1'b0;
        wb_valid  = 1'b0;
        wb_addr   = '0;
        wb_data   = '0;
        wb_size   = '0;
        cycles    = 0;
        held      = 1'b0;
        while (rst !== 1'b0 && cycles < RST_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst !== 1'b0) begin
            report_error("timeout: reset was never released");
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            @(posedge clk);
            if (wb_valid) begin
                model_write(wb_addr, wb_data, wb_size);
            end
            wb_valid <= 1'b1;
            wb_addr  <= addr_t'(i) << 3;
            wb_data  <= {addr_t'(i) * 32'h9e37_79b9, ~addr_t'(i)};
            wb_size  <= SZ_QWORD;
        end
        cycles = 0;
        while (accepted < N_INSTR && cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
            // held tracks whether the output register carries a result.
            check_flag("valid_out", valid_out, held);
            check_flag("stall", stall, fwd_stall && held);
            nxt = ins;
            if (!stall) begin
                held = ins.valid;
                if (ins.valid) begin
                    sz = eff_size(ins.opsize, ins.ovr);
                    if (ins.acc1) begin
                        last_load = model_read(ins.addr1, sz);
                    end
                    exp_q.push_back(ref_mem_stage(ins, last_load));
                    accepted++;
                end
                if (accepted < N_INSTR) begin
                    nxt = random_instr();
                end else begin
                    nxt = '0;
                end
            end
            // the load above saw the RAM before this edge's write.
            if (wb_valid) begin
                model_write(wb_addr, wb_data, wb_size);
            end
            ins <= nxt;
            drive_wb(nxt.addr1);
            r = rand32();
            fwd_stall <= r[1:0] == 2'b00;
        end
        if (accepted < N_INSTR) begin
            report_error("timeout: the stage stopped accepting instructions");
        end
        fwd_stall <= 1'b0;
        wb_valid  <= 1'b0;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            report_error("timeout: results still pending after the last instruction");
        end
        // the stage falls idle once the last result is taken.
        @(posedge clk);
        if (valid_out) begin
            report_error("valid_out still high after the last result was taken");
        end else begin
            passed = 1'b1;
            $display("No errors");
            $finish;
        end
    end

    initial begin : compare_results
        result_t e;
        forever begin
            @(posedge clk);
            if (rst === 1'b0) begin
                if (valid_out && !fwd_stall) begin
                    if (exp_q.size() == 0) begin
                        report_error("valid_out high with no result expected");
                    end
                    e = exp_q.pop_front();
                    check_data("op1_val", op1_val, e.op1);
                    check_data("op2_val", op2_val, e.op2);
                    check_addr("dest_addr", dest_addr, e.dest);
                    check_size("size_out", size_out, e.size);
                    check_ie(ie_out, ie_type_out, e.ie, e.ie_type);
                    check_aluk("aluk_out", aluk_out, e.aluk);
                end else if (!valid_out) begin
                    // bubbles never carry an exception.
                    check_ie(ie_out, ie_type_out, 1'b0, '0);
                end
            end
        end
    end

    final begin
        if (!passed) begin
            show_fail();
        end
    end

endmodule

// File: mem_stage.f
common/mem_types_pkg.sv
common/mem_cfg_pkg.sv
hw/addr_gen.sv
hw/seg_limit_check.sv
hw/operand_select.sv
data_ram/data_ram.sv
hw/mem_stage.sv
verification/clk_gen.sv
verification/mem_stage_chk.sv
verification/mem_stage_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := mem_stage_tb
FILELIST  := mem_stage.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Errors found
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
